// ==== all.f ====
+incdir+include
logic/cpuIsaPkg.sv
logic/cpuPipePkg.sv
logic/regFile.sv
logic/instrDecode.sv
logic/aluExecute.sv
logic/resultWriteback.sv
logic/miniCore.sv
verification/clockGen.sv
verification/miniCoreTb.sv

// ==== include/cpu_config.svh ====
// Core configuration macros
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Data word size in bits
`define WORD_WIDTH 32

// Architectural registers
`define REG_COUNT 16

// Instruction queue entries, also the sender's credits after reset
`define INSTR_DEPTH 4

// Output slots the consumer grants after reset
`define OUT_CREDITS 2

`endif

// ==== logic/aluExecute.sv ====
// Execute stage ALU
`timescale 1ns/10ps
`include "cpu_config.svh"

module aluExecute (
   input  logic                    Clock,
   input  logic                    rstN,
   input  cpuPipePkg::decodedOp_t  issueOp,
   input  logic                    stall,
   output cpuPipePkg::execResult_t execOut
);
   import cpuIsaPkg::*;
   import cpuPipePkg::*;

   localparam int ShW = $clog2(`WORD_WIDTH);

   word_t          aluResult;
   logic [ShW-1:0] shiftAmt;

   // Shift distance from the low bits of operand B
   assign shiftAmt = issueOp.operandB[ShW-1:0];

   always_comb begin
      case (issueOp.opcode)
         opLdi, opAddi, opAdd: begin
            aluResult = issueOp.operandA + issueOp.operandB;
         end
         opSub: begin
            aluResult = issueOp.operandA - issueOp.operandB;
         end
         opAnd, opAndi: begin
            aluResult = issueOp.operandA & issueOp.operandB;
         end
         opOr, opOri: begin
            aluResult = issueOp.operandA | issueOp.operandB;
         end
         opShl: begin
            aluResult = issueOp.operandA << shiftAmt;
         end
         opShr: begin
            aluResult = issueOp.operandA >> shiftAmt;
         end
         // out passes its register value through
         default: begin
            aluResult = issueOp.operandA;
         end
      endcase
   end

   always_ff @(posedge Clock) begin
      if (!rstN) begin
         execOut.valid <= 1'b0;
      end else if (!stall) begin
         execOut.opcode <= issueOp.opcode;
         execOut.dest   <= issueOp.dest;
         execOut.result <= aluResult;
         // nop dies here
         execOut.valid  <= issueOp.valid && (issueOp.opcode != opNop);
      end
   end

endmodule

// ==== logic/cpuIsaPkg.sv ====
// Instruction set types
`include "cpu_config.svh"

package cpuIsaPkg;

   // Data word and field types
   typedef logic [`WORD_WIDTH-1:0] word_t;
   typedef logic [3:0]             regIdx_t;
   typedef logic [18:0]            const_t;

   // Opcode sits in the top five bits of the instruction
   typedef enum logic [4:0] {
      opLdi  = 5'b00001,
      opAdd  = 5'b00011,
      opSub  = 5'b00100,
      opAnd  = 5'b00101,
      opOr   = 5'b00110,
      opShr  = 5'b00111,
      opShl  = 5'b01000,
      opAddi = 5'b01100,
      opAndi = 5'b01101,
      opOri  = 5'b01110,
      opOut  = 5'b10111,
      opNop  = 5'b11010
   } opcode_t;

endpackage

// ==== logic/cpuPipePkg.sv ====
// Pipeline stage records
package cpuPipePkg;

   // Decode to execute
   typedef struct packed {
      cpuIsaPkg::opcode_t opcode;
      // Destination register, Ra of the instruction
      cpuIsaPkg::regIdx_t dest;
      // Already zero for ldi with base R0
      cpuIsaPkg::word_t   operandA;
      // Register value or sign-extended constant
      cpuIsaPkg::word_t   operandB;
      logic               valid;
   } decodedOp_t;

   // Execute to result
   typedef struct packed {
      cpuIsaPkg::opcode_t opcode;
      cpuIsaPkg::regIdx_t dest;
      cpuIsaPkg::word_t   result;
      logic               valid;
   } execResult_t;

endpackage

// ==== logic/instrDecode.sv ====
// Instruction queue, decode and issue
`timescale 1ns/10ps
`include "cpu_config.svh"

module instrDecode (
   input  logic                   Clock,
   input  logic                   rstN,
   input  logic                   instrValid,
   input  cpuIsaPkg::word_t       instrWord,
   output logic                   instrCredit,
   output cpuIsaPkg::regIdx_t     readIdxA,
   output cpuIsaPkg::regIdx_t     readIdxB,
   input  cpuIsaPkg::word_t       readDataA,
   input  cpuIsaPkg::word_t       readDataB,
   input  logic                   writeEn,
   input  cpuIsaPkg::regIdx_t     writeIdx,
   input  logic                   stall,
   output cpuPipePkg::decodedOp_t issueOp
);
   import cpuIsaPkg::*;
   import cpuPipePkg::*;

   localparam int PtrW   = $clog2(`INSTR_DEPTH);
   localparam int ConstW = $bits(const_t);
   localparam int OpLsb  = `WORD_WIDTH - $bits(opcode_t);
   localparam int RaLsb  = OpLsb - $bits(regIdx_t);
   localparam int RbLsb  = RaLsb - $bits(regIdx_t);
   localparam int RcLsb  = RbLsb - $bits(regIdx_t);

   word_t                 queue [`INSTR_DEPTH];
   logic [PtrW-1:0]       wrPtr;
   logic [PtrW-1:0]       rdPtr;
   logic [PtrW:0]         count;
   logic [`REG_COUNT-1:0] pending;

   word_t      headWord;
   word_t      constExt;
   word_t      opndA;
   word_t      opndB;
   opcode_t    headOp;
   regIdx_t    fieldRa;
   regIdx_t    fieldRb;
   regIdx_t    fieldRc;
   const_t     fieldConst;
   logic       headValid;
   logic       knownOp;
   logic       needA;
   logic       needB;
   logic       setsDest;
   logic       hazard;
   logic       canIssue;
   logic       pop;
   decodedOp_t nextOp;

   function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] ptr);
      return (ptr == PtrW'(`INSTR_DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   // Fields of the instruction at the head of the queue
   assign headWord   = queue[rdPtr];
   assign headValid  = (count != '0);
   assign headOp     = opcode_t'(headWord[OpLsb +: $bits(opcode_t)]);
   assign fieldRa    = headWord[RaLsb +: $bits(regIdx_t)];
   assign fieldRb    = headWord[RbLsb +: $bits(regIdx_t)];
   assign fieldRc    = headWord[RcLsb +: $bits(regIdx_t)];
   assign fieldConst = headWord[ConstW-1:0];
   assign constExt   = {{(`WORD_WIDTH - ConstW){fieldConst[ConstW-1]}}, fieldConst};

   // out reads Ra, everything else reads Rb and Rc
   assign readIdxA = (headOp == opOut) ? fieldRa : fieldRb;
   assign readIdxB = fieldRc;

   always_comb begin
      knownOp  = 1'b1;
      needA    = 1'b0;
      needB    = 1'b0;
      setsDest = 1'b0;
      opndA    = readDataA;
      opndB    = constExt;
      case (headOp)
         opLdi: begin
            // Base register R0 means no base at all
            needA    = (fieldRb != '0);
            setsDest = 1'b1;
            if (fieldRb == '0) begin
               opndA = '0;
            end
         end
         opAddi, opAndi, opOri: begin
            needA    = 1'b1;
            setsDest = 1'b1;
         end
         opAdd, opSub, opAnd, opOr, opShl, opShr: begin
            needA    = 1'b1;
            needB    = 1'b1;
            setsDest = 1'b1;
            opndB    = readDataB;
         end
         opOut: begin
            needA = 1'b1;
            opndB = '0;
         end
         opNop: opndB = '0;
         default: knownOp = 1'b0;
      endcase
   end

   // Wait on pending sources, and on a pending destination to keep writes ordered
   assign hazard = (needA && pending[readIdxA]) || (needB && pending[readIdxB])
                   || (setsDest && pending[fieldRa]);
   // Undefined opcodes leave the queue without issuing
   assign pop      = headValid && !stall && !hazard;
   assign canIssue = pop && knownOp;
   assign nextOp   = '{opcode: headOp, dest: fieldRa, operandA: opndA,
                       operandB: opndB, valid: canIssue};

   always_ff @(posedge Clock) begin
      if (instrValid) begin
         queue[wrPtr] <= instrWord;
      end
   end

   always_ff @(posedge Clock) begin
      if (!rstN) begin
         wrPtr         <= '0;
         rdPtr         <= '0;
         count         <= '0;
         instrCredit   <= 1'b0;
         pending       <= '0;
         issueOp.valid <= 1'b0;
      end else begin
         if (instrValid) begin
            wrPtr <= nextPtr(wrPtr);
         end
         if (pop) begin
            rdPtr <= nextPtr(rdPtr);
         end
         case ({instrValid, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         // One credit back per freed entry
         instrCredit <= pop;
         if (writeEn) begin
            pending[writeIdx] <= 1'b0;
         end
         if (canIssue && setsDest) begin
            pending[fieldRa] <= 1'b1;
         end
         if (!stall) begin
            issueOp <= nextOp;
         end
      end
   end

   // Sender spends a credit per beat, so a full queue never sees one
   assert property (@(posedge Clock) disable iff (!rstN)
      instrValid |-> count < `INSTR_DEPTH);

   // Operands come straight from the register file, so no write may be in flight
   assert property (@(posedge Clock) disable iff (!rstN)
      canIssue |-> !(needA && (pending[readIdxA] || (writeEn && writeIdx == readIdxA)))
                && !(needB && (pending[readIdxB] || (writeEn && writeIdx == readIdxB))));

endmodule

// ==== logic/miniCore.sv ====
// Core top level
`timescale 1ns/10ps

module miniCore (
   input  logic             Clock,
   input  logic             rstN,
   input  logic             instrValid,
   input  cpuIsaPkg::word_t instrWord,
   output logic             instrCredit,
   output logic             outValid,
   output cpuIsaPkg::word_t outData,
   input  logic             outCredit
);
   import cpuIsaPkg::*;
   import cpuPipePkg::*;

   regIdx_t     readIdxA;
   regIdx_t     readIdxB;
   regIdx_t     writeIdx;
   word_t       readDataA;
   word_t       readDataB;
   word_t       writeData;
   logic        writeEn;
   logic        stall;
   decodedOp_t  issueOp;
   execResult_t execOut;

   regFile u_regFile (
      .Clock     (Clock),
      .rstN      (rstN),
      .readIdxA  (readIdxA),
      .readIdxB  (readIdxB),
      .readDataA (readDataA),
      .readDataB (readDataB),
      .writeEn   (writeEn),
      .writeIdx  (writeIdx),
      .writeData (writeData)
   );

   instrDecode u_decode (
      .Clock       (Clock),
      .rstN        (rstN),
      .instrValid  (instrValid),
      .instrWord   (instrWord),
      .instrCredit (instrCredit),
      .readIdxA    (readIdxA),
      .readIdxB    (readIdxB),
      .readDataA   (readDataA),
      .readDataB   (readDataB),
      .writeEn     (writeEn),
      .writeIdx    (writeIdx),
      .stall       (stall),
      .issueOp     (issueOp)
   );

   aluExecute u_execute (
      .Clock   (Clock),
      .rstN    (rstN),
      .issueOp (issueOp),
      .stall   (stall),
      .execOut (execOut)
   );

   resultWriteback u_result (
      .Clock     (Clock),
      .rstN      (rstN),
      .execOut   (execOut),
      .writeEn   (writeEn),
      .writeIdx  (writeIdx),
      .writeData (writeData),
      .outValid  (outValid),
      .outData   (outData),
      .outCredit (outCredit),
      .stall     (stall)
   );

endmodule

// ==== logic/regFile.sv ====
// General purpose register file
`timescale 1ns/10ps
`include "cpu_config.svh"

module regFile (
   input  logic               Clock,
   input  logic               rstN,
   input  cpuIsaPkg::regIdx_t readIdxA,
   input  cpuIsaPkg::regIdx_t readIdxB,
   output cpuIsaPkg::word_t   readDataA,
   output cpuIsaPkg::word_t   readDataB,
   input  logic               writeEn,
   input  cpuIsaPkg::regIdx_t writeIdx,
   input  cpuIsaPkg::word_t   writeData
);
   import cpuIsaPkg::*;

   word_t regs [`REG_COUNT];

   // Reads are combinational, no bypass from the write port
   assign readDataA = regs[readIdxA];
   assign readDataB = regs[readIdxB];

   always_ff @(posedge Clock) begin
      if (!rstN) begin
         for (int i = 0; i < `REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (writeEn) begin
         regs[writeIdx] <= writeData;
      end
   end

endmodule

// ==== logic/resultWriteback.sv ====
// Register write-back and output port
`timescale 1ns/10ps
`include "cpu_config.svh"

module resultWriteback (
   input  logic                    Clock,
   input  logic                    rstN,
   input  cpuPipePkg::execResult_t execOut,
   output logic                    writeEn,
   output cpuIsaPkg::regIdx_t      writeIdx,
   output cpuIsaPkg::word_t        writeData,
   output logic                    outValid,
   output cpuIsaPkg::word_t        outData,
   input  logic                    outCredit,
   output logic                    stall
);
   import cpuIsaPkg::*;
   import cpuPipePkg::*;

   localparam int CreditW = $clog2(`OUT_CREDITS + 1);

   logic [CreditW-1:0] credits;
   logic               isOut;
   logic               haveCredit;

   assign isOut      = execOut.valid && (execOut.opcode == opOut);
   assign haveCredit = (credits != '0);

   // Register results write in the cycle they arrive
   assign writeEn   = execOut.valid && !isOut;
   assign writeIdx  = execOut.dest;
   assign writeData = execOut.result;

   // out waits here until the consumer has room
   assign outValid = isOut && haveCredit;
   assign outData  = execOut.result;
   assign stall    = isOut && !haveCredit;

   always_ff @(posedge Clock) begin
      if (!rstN) begin
         credits <= CreditW'(`OUT_CREDITS);
      end else begin
         case ({outCredit, outValid})
            2'b10:   credits <= credits + 1'b1;
            2'b01:   credits <= credits - 1'b1;
            default: credits <= credits;
         endcase
      end
   end

   // Consumer never returns more than it granted
   assert property (@(posedge Clock) disable iff (!rstN)
      !(outValid && credits == '0) && credits <= CreditW'(`OUT_CREDITS));

endmodule

// ==== verification/clockGen.sv ====
// Testbench clock and reset
`timescale 1ns/10ps

module clockGen (
   output logic Clock,
   output logic rstN
);

   // 100 ns period
   initial begin
      Clock = 1'b0;
      forever #50 Clock = ~Clock;
   end

   // Reset held low for eight rising edges
   initial begin
      rstN = 1'b0;
      repeat (8) @(posedge Clock);
      rstN <= 1'b1;
   end

endmodule

// ==== verification/miniCoreTb.sv ====
// Core directed tests
`timescale 1ns/10ps
`include "cpu_config.svh"

module miniCoreTb;
   import cpuIsaPkg::*;

   logic  Clock;
   logic  rstN;
   logic  instrValid;
   word_t instrWord;
   logic  instrCredit;
   logic  outValid;
   word_t outData;
   logic  outCredit = 1'b0;

   word_t refRegs [16];
   word_t instrQ [$];
   word_t expQ [$];
   int    returnAt [$];
   string testName = "reset";
   int    valueErrors = 0;
   int    otherErrors = 0;
   int    totalInstr = 0;
   int    beatsSent = 0;
   int    creditsBack = 0;
   int    heldCredits = `OUT_CREDITS;
   int    outsSeen = 0;
   int    creditDelay = 1;
   int    cycle = 0;

   clockGen u_clockGen (.Clock(Clock), .rstN(rstN));

   miniCore u_dut (
      .Clock       (Clock),
      .rstN        (rstN),
      .instrValid  (instrValid),
      .instrWord   (instrWord),
      .instrCredit (instrCredit),
      .outValid    (outValid),
      .outData     (outData),
      .outCredit   (outCredit)
   );

   task automatic compareWord(input string name, input word_t expected, input word_t actual);
      if (expected !== actual) begin
         valueErrors++;
         $display("Fail %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   task automatic compareCount(input string name, input int expected, input int actual);
      if (expected != actual) begin
         valueErrors++;
         $display("Fail %s: expected %0d, actual %0d", name, expected, actual);
      end
   endtask

   // Reference model applied in program order
   function automatic void modelInstr(input word_t w);
      opcode_t op;
      regIdx_t ra;
      regIdx_t rb;
      word_t   a;
      word_t   b;
      word_t   c;
      op = opcode_t'(w[31:27]);
      ra = w[26:23];
      rb = w[22:19];
      a  = refRegs[rb];
      b  = refRegs[w[18:15]];
      c  = {{13{w[18]}}, w[18:0]};
      case (op)
         opLdi:  refRegs[ra] = ((rb == 4'd0) ? 32'd0 : a) + c;
         opAddi: refRegs[ra] = a + c;
         opAndi: refRegs[ra] = a & c;
         opOri:  refRegs[ra] = a | c;
         opAdd:  refRegs[ra] = a + b;
         opSub:  refRegs[ra] = a - b;
         opAnd:  refRegs[ra] = a & b;
         opOr:   refRegs[ra] = a | b;
         opShl:  refRegs[ra] = a << b[4:0];
         opShr:  refRegs[ra] = a >> b[4:0];
         opOut:  expQ.push_back(refRegs[ra]);
         default: ;
      endcase
   endfunction

   function automatic word_t iWord(opcode_t op, regIdx_t ra, regIdx_t rb, const_t c);
      return {op, ra, rb, c};
   endfunction

   function automatic word_t rWord(opcode_t op, regIdx_t ra, regIdx_t rb, regIdx_t rc);
      return {op, ra, rb, rc, 15'd0};
   endfunction

   task automatic emit(input word_t w);
      modelInstr(w);
      instrQ.push_back(w);
      totalInstr++;
   endtask

   // Sender spends one credit per beat
   task automatic runProgram();
      int avail;
      while (instrQ.size() != 0) begin
         @(posedge Clock);
         avail = `INSTR_DEPTH + creditsBack - beatsSent;
         if (avail > `INSTR_DEPTH) begin
            otherErrors++;
            $display("More instruction credits returned than beats sent in %s", testName);
         end
         if (avail > 0) begin
            instrValid <= 1'b1;
            instrWord  <= instrQ.pop_front();
            beatsSent++;
         end else begin
            instrValid <= 1'b0;
         end
      end
      @(posedge Clock);
      instrValid <= 1'b0;
   endtask

   task automatic drainOutputs();
      while (expQ.size() != 0 || returnAt.size() != 0) begin
         @(posedge Clock);
      end
      repeat (2) @(posedge Clock);
   endtask

   always @(posedge Clock) begin
      if (rstN && instrCredit) begin
         creditsBack <= creditsBack + 1;
      end
   end

   // Consumer returns each credit after creditDelay cycles
   always @(posedge Clock) begin
      if (rstN) begin
         if (outValid) begin
            outsSeen++;
            if (heldCredits <= 0) begin
               otherErrors++;
               $display("Output beat sent with no credit held in %s", testName);
            end
            if (expQ.size() == 0) begin
               otherErrors++;
               $display("Unexpected output %h in %s", outData, testName);
            end else begin
               compareWord(testName, expQ.pop_front(), outData);
            end
            returnAt.push_back(cycle + creditDelay);
         end
         heldCredits = heldCredits + int'(outCredit) - int'(outValid);
         if (returnAt.size() != 0 && returnAt[0] <= cycle) begin
            outCredit <= 1'b1;
            void'(returnAt.pop_front());
         end else begin
            outCredit <= 1'b0;
         end
      end
   end

   // Limit grows with every instruction emitted
   always @(posedge Clock) begin
      cycle <= cycle + 1;
      if (cycle > totalInstr * 20 + 200) begin
         $display("Run hung after %0d cycles in %s", cycle, testName);
         $display("Errors: %0d value, %0d other", valueErrors, otherErrors);
         $display("TEST FAIL");
         $finish;
      end
   end

   task automatic ldiConstants();
      const_t vals [5] = '{19'h00005, 19'h7ffff, 19'h3ffff, 19'h40000, 19'h12345};
      testName = "ldiConstants";
      for (int i = 0; i < 5; i++) begin
         emit(iWord(opLdi, regIdx_t'(i + 1), 4'd0, vals[i]));
      end
      for (int i = 0; i < 5; i++) begin
         emit(iWord(opOut, regIdx_t'(i + 1), 4'd0, '0));
      end
      runProgram();
      drainOutputs();
   endtask

   task automatic ldiBase();
      testName = "ldiBase";
      repeat (3) begin
         emit(iWord(opLdi, 4'd1, 4'd0, const_t'($urandom)));
         emit(iWord(opLdi, 4'd2, 4'd0, const_t'($urandom)));
         emit(iWord(opLdi, 4'd3, 4'd1, const_t'($urandom)));
         emit(iWord(opAddi, 4'd4, 4'd2, const_t'($urandom)));
         emit(iWord(opAndi, 4'd5, 4'd3, const_t'($urandom)));
         emit(iWord(opOri, 4'd6, 4'd1, const_t'($urandom)));
         for (int r = 3; r <= 6; r++) begin
            emit(iWord(opOut, regIdx_t'(r), 4'd0, '0));
         end
      end
      runProgram();
      drainOutputs();
   endtask

   task automatic registerOps();
      testName = "registerOps";
      repeat (3) begin
         emit(iWord(opLdi, 4'd1, 4'd0, const_t'($urandom)));
         emit(iWord(opLdi, 4'd2, 4'd0, const_t'($urandom)));
         emit(iWord(opLdi, 4'd3, 4'd0, const_t'($urandom)));
         emit(iWord(opLdi, 4'd4, 4'd0, const_t'($urandom % 32)));
         emit(rWord(opAdd, 4'd5, 4'd1, 4'd2));
         emit(rWord(opSub, 4'd6, 4'd1, 4'd2));
         emit(rWord(opAnd, 4'd7, 4'd1, 4'd3));
         emit(rWord(opOr, 4'd8, 4'd2, 4'd3));
         emit(rWord(opShl, 4'd9, 4'd1, 4'd4));
         emit(rWord(opShr, 4'd10, 4'd2, 4'd4));
         for (int r = 5; r <= 10; r++) begin
            emit(iWord(opOut, regIdx_t'(r), 4'd0, '0));
         end
      end
      runProgram();
      drainOutputs();
   endtask

   // Every step reads the previous destination
   task automatic dependentChain();
      regIdx_t prev;
      regIdx_t dest;
      testName = "dependentChain";
      emit(iWord(opLdi, 4'd8, 4'd0, const_t'($urandom)));
      emit(iWord(opLdi, 4'd11, 4'd0, const_t'($urandom)));
      prev = 4'd11;
      for (int i = 0; i < 16; i++) begin
         dest = regIdx_t'(11 + (i % 3));
         case (i % 4)
            0: emit(iWord(opAddi, dest, prev, const_t'($urandom)));
            1: emit(rWord(opSub, dest, prev, 4'd8));
            2: emit(iWord(opLdi, dest, prev, const_t'($urandom)));
            default: emit(rWord(opAdd, dest, prev, prev));
         endcase
         prev = dest;
      end
      for (int r = 11; r <= 13; r++) begin
         emit(iWord(opOut, regIdx_t'(r), 4'd0, '0));
      end
      runProgram();
      drainOutputs();
   endtask

   task automatic outputBackPressure();
      int outsBefore;
      testName = "outputBackPressure";
      outsBefore = outsSeen;
      creditDelay = 30;
      for (int r = 1; r <= 3; r++) begin
         emit(iWord(opLdi, regIdx_t'(r), 4'd0, const_t'($urandom)));
      end
      for (int i = 0; i < 8; i++) begin
         emit(iWord(opOut, regIdx_t'(1 + (i % 3)), 4'd0, '0));
         if (i == 3) begin
            emit(iWord(opAddi, 4'd1, 4'd1, 19'd1));
         end
      end
      runProgram();
      drainOutputs();
      compareCount(testName, 8, outsSeen - outsBefore);
      creditDelay = 1;
   endtask

   task automatic instructionCredits();
      testName = "instructionCredits";
      emit(iWord(opLdi, 4'd1, 4'd0, const_t'($urandom)));
      for (int i = 0; i < 16; i++) begin
         if (i % 2 == 0) begin
            emit(iWord(opNop, 4'd0, 4'd0, '0));
         end else begin
            emit(iWord(opAddi, 4'd1, 4'd1, const_t'($urandom)));
         end
         if (i % 5 == 4) begin
            emit(iWord(opOut, 4'd1, 4'd0, '0));
         end
      end
      emit(iWord(opOut, 4'd1, 4'd0, '0));
      runProgram();
      drainOutputs();
      compareCount(testName, beatsSent, creditsBack);
   endtask

   initial begin
      instrValid = 1'b0;
      instrWord  = '0;
      void'($urandom(14266));
      for (int r = 0; r < 16; r++) begin
         refRegs[r] = '0;
      end
      wait (rstN);
      @(posedge Clock);
      ldiConstants();
      ldiBase();
      registerOps();
      dependentChain();
      outputBackPressure();
      instructionCredits();
      $display("Errors: %0d value, %0d other", valueErrors, otherErrors);
      if (valueErrors + otherErrors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule
